/* hdl/raster_pkg.sv */
// ==========================================================================
// Shared types and command encoding for the triangle rasterizer.
// Modules refer to these by scoped names.
// ==========================================================================

package raster_pkg;

    // whole-pixel signed coordinate
    typedef logic signed [11:0] coord_t;

    // product of two coordinate differences
    typedef logic signed [25:0] edge_t;

    typedef logic [15:0] color_t;

    typedef logic [31:0] cmd_t;

    // command word layout
    localparam int OP_POS    = 24;
    localparam int OP_SIZE   = 8;
    localparam int DATA_SIZE = 16;

    // opcodes, anything else is ignored
    localparam logic [7:0] OP_SET_X0    = 8'd0;
    localparam logic [7:0] OP_SET_Y0    = 8'd1;
    localparam logic [7:0] OP_SET_X1    = 8'd2;
    localparam logic [7:0] OP_SET_Y1    = 8'd3;
    localparam logic [7:0] OP_SET_X2    = 8'd4;
    localparam logic [7:0] OP_SET_Y2    = 8'd5;
    localparam logic [7:0] OP_SET_COLOR = 8'd6;
    localparam logic [7:0] OP_CLEAR     = 8'd7;
    localparam logic [7:0] OP_DRAW      = 8'd8;
    localparam logic [7:0] OP_SWAP      = 8'd9;

endpackage

/* hdl/command_decoder.sv */
// ==========================================================================
// Command stream front end. Loads vertex and colour registers, pulses
// the draw, clear and swap strobes and holds ready low while a job runs.
// ==========================================================================

`timescale 1ns/1ps

module command_decoder (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                cmd_valid_i,
    input  raster_pkg::cmd_t    cmd_data_i,
    input  logic                job_done_i,
    output logic                cmd_ready_o,
    output logic                draw_start_o,
    output logic                clear_start_o,
    output logic                swap_o,
    output raster_pkg::coord_t  x0_o,
    output raster_pkg::coord_t  y0_o,
    output raster_pkg::coord_t  x1_o,
    output raster_pkg::coord_t  y1_o,
    output raster_pkg::coord_t  x2_o,
    output raster_pkg::coord_t  y2_o,
    output raster_pkg::color_t  fill_color_o,
    output raster_pkg::color_t  clear_color_o
);

    typedef enum logic [1:0] {
        IDLE,
        PROCESS,
        BUSY
    } state_t;

    state_t                              state_q;
    logic                                accept;
    logic [raster_pkg::OP_SIZE-1:0]      op;
    logic [raster_pkg::DATA_SIZE-1:0]    data;
    raster_pkg::coord_t                  coord;

    assign op    = cmd_data_i[raster_pkg::OP_POS +: raster_pkg::OP_SIZE];
    assign data  = cmd_data_i[raster_pkg::DATA_SIZE-1:0];
    assign coord = data[$bits(raster_pkg::coord_t)-1:0];

    assign cmd_ready_o = (state_q == IDLE);
    assign accept      = cmd_ready_o && cmd_valid_i;

    // start strobes fire in the accept cycle so the clear fill begins next cycle
    assign draw_start_o  = accept && (op == raster_pkg::OP_DRAW);
    assign clear_start_o = accept && (op == raster_pkg::OP_CLEAR);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q       <= IDLE;
            swap_o        <= 1'b0;
            x0_o          <= '0;
            y0_o          <= '0;
            x1_o          <= '0;
            y1_o          <= '0;
            x2_o          <= '0;
            y2_o          <= '0;
            fill_color_o  <= '0;
            clear_color_o <= '0;
        end else begin
            swap_o <= accept && (op == raster_pkg::OP_SWAP);
            case (state_q)
                IDLE: begin
                    if (accept) begin
                        case (op)
                            raster_pkg::OP_SET_X0:    x0_o <= coord;
                            raster_pkg::OP_SET_Y0:    y0_o <= coord;
                            raster_pkg::OP_SET_X1:    x1_o <= coord;
                            raster_pkg::OP_SET_Y1:    y1_o <= coord;
                            raster_pkg::OP_SET_X2:    x2_o <= coord;
                            raster_pkg::OP_SET_Y2:    y2_o <= coord;
                            raster_pkg::OP_SET_COLOR: fill_color_o <= data;
                            raster_pkg::OP_CLEAR:     clear_color_o <= data;
                            default: ;
                        endcase
                        if (draw_start_o || clear_start_o) begin
                            state_q <= BUSY;
                        end else begin
                            state_q <= PROCESS;
                        end
                    end
                end
                PROCESS: state_q <= IDLE;
                BUSY: begin
                    if (job_done_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

/* hdl/bbox_setup.sv */
// ==========================================================================
// Triangle bounding box, clamped to the framebuffer and registered.
// An off-screen triangle leaves min above max on some axis.
// ==========================================================================

`timescale 1ns/1ps

module bbox_setup #(
    parameter int FB_WIDTH  = 128,
    parameter int FB_HEIGHT = 128
) (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                draw_start_i,
    input  raster_pkg::coord_t  x0_i,
    input  raster_pkg::coord_t  y0_i,
    input  raster_pkg::coord_t  x1_i,
    input  raster_pkg::coord_t  y1_i,
    input  raster_pkg::coord_t  x2_i,
    input  raster_pkg::coord_t  y2_i,
    output logic                scan_start_o,
    output raster_pkg::coord_t  min_x_o,
    output raster_pkg::coord_t  min_y_o,
    output raster_pkg::coord_t  max_x_o,
    output raster_pkg::coord_t  max_y_o
);

    localparam raster_pkg::coord_t X_LIMIT = raster_pkg::coord_t'(FB_WIDTH - 1);
    localparam raster_pkg::coord_t Y_LIMIT = raster_pkg::coord_t'(FB_HEIGHT - 1);

    raster_pkg::coord_t lo_x, lo_y, hi_x, hi_y;

    function automatic raster_pkg::coord_t min3(input raster_pkg::coord_t a,
                                                input raster_pkg::coord_t b,
                                                input raster_pkg::coord_t c);
        raster_pkg::coord_t m;
        m = (a < b) ? a : b;
        return (c < m) ? c : m;
    endfunction

    function automatic raster_pkg::coord_t max3(input raster_pkg::coord_t a,
                                                input raster_pkg::coord_t b,
                                                input raster_pkg::coord_t c);
        raster_pkg::coord_t m;
        m = (a > b) ? a : b;
        return (c > m) ? c : m;
    endfunction

    assign lo_x = min3(x0_i, x1_i, x2_i);
    assign lo_y = min3(y0_i, y1_i, y2_i);
    assign hi_x = max3(x0_i, x1_i, x2_i);
    assign hi_y = max3(y0_i, y1_i, y2_i);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            scan_start_o <= 1'b0;
            min_x_o      <= '0;
            min_y_o      <= '0;
            max_x_o      <= '0;
            max_y_o      <= '0;
        end else begin
            scan_start_o <= draw_start_i;
            if (draw_start_i) begin
                min_x_o <= (lo_x < 0) ? '0 : lo_x;
                min_y_o <= (lo_y < 0) ? '0 : lo_y;
                max_x_o <= (hi_x > X_LIMIT) ? X_LIMIT : hi_x;
                max_y_o <= (hi_y > Y_LIMIT) ? Y_LIMIT : hi_y;
            end
        end
    end

endmodule

/* hdl/pixel_scanner.sv */
// ==========================================================================
// Walks the bounding box row by row, one pixel per cycle. An empty box
// produces a single last token with no valid pixel.
// ==========================================================================

`timescale 1ns/1ps

module pixel_scanner #(
    parameter int FB_WIDTH  = 128,
    parameter int FB_HEIGHT = 128
) (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                scan_start_i,
    input  raster_pkg::coord_t  min_x_i,
    input  raster_pkg::coord_t  min_y_i,
    input  raster_pkg::coord_t  max_x_i,
    input  raster_pkg::coord_t  max_y_i,
    output logic                pix_valid_o,
    output logic                pix_last_o,
    output raster_pkg::coord_t  pix_x_o,
    output raster_pkg::coord_t  pix_y_o
);

    logic               box_empty;
    logic               scanning;
    logic               row_end;
    raster_pkg::coord_t next_x, next_y;

    assign box_empty = (min_x_i > max_x_i) || (min_y_i > max_y_i);

    assign scanning = pix_valid_o && !pix_last_o;
    assign row_end  = (pix_x_o == max_x_i);
    assign next_x   = row_end ? min_x_i : pix_x_o + raster_pkg::coord_t'(1);
    assign next_y   = row_end ? pix_y_o + raster_pkg::coord_t'(1) : pix_y_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pix_valid_o <= 1'b0;
            pix_last_o  <= 1'b0;
            pix_x_o     <= '0;
            pix_y_o     <= '0;
        end else if (scan_start_i) begin
            pix_valid_o <= !box_empty;
            pix_last_o  <= box_empty || ((min_x_i == max_x_i) && (min_y_i == max_y_i));
            pix_x_o     <= min_x_i;
            pix_y_o     <= min_y_i;
        end else if (scanning) begin
            pix_valid_o <= 1'b1;
            pix_last_o  <= (next_x == max_x_i) && (next_y == max_y_i);
            pix_x_o     <= next_x;
            pix_y_o     <= next_y;
        end else begin
            pix_valid_o <= 1'b0;
            pix_last_o  <= 1'b0;
        end
    end

endmodule

/* hdl/edge_evaluator.sv */
// ==========================================================================
// Edge-function inside test, two pipeline stages. Stage one forms the
// six products, stage two takes the three differences and the sign test.
// ==========================================================================

`timescale 1ns/1ps

module edge_evaluator (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                pix_valid_i,
    input  logic                pix_last_i,
    input  raster_pkg::coord_t  pix_x_i,
    input  raster_pkg::coord_t  pix_y_i,
    input  raster_pkg::coord_t  x0_i,
    input  raster_pkg::coord_t  y0_i,
    input  raster_pkg::coord_t  x1_i,
    input  raster_pkg::coord_t  y1_i,
    input  raster_pkg::coord_t  x2_i,
    input  raster_pkg::coord_t  y2_i,
    output logic                cov_valid_o,
    output logic                cov_last_o,
    output raster_pkg::coord_t  cov_x_o,
    output raster_pkg::coord_t  cov_y_o
);

    // one extra bit so the difference of two products cannot wrap
    typedef logic signed [$bits(raster_pkg::edge_t):0] wide_t;

    raster_pkg::edge_t  p0a_q, p0b_q, p1a_q, p1b_q, p2a_q, p2b_q;
    logic               valid_q, last_q;
    raster_pkg::coord_t x_q, y_q;
    wide_t              w0, w1, w2;

    // product (a - b) * (c - d) of coordinate differences
    function automatic raster_pkg::edge_t mul(input raster_pkg::coord_t a,
                                              input raster_pkg::coord_t b,
                                              input raster_pkg::coord_t c,
                                              input raster_pkg::coord_t d);
        logic signed [12:0] da, dc;
        da = {a[11], a} - {b[11], b};
        dc = {c[11], c} - {d[11], d};
        return da * dc;
    endfunction

    assign w0 = wide_t'(p0a_q) - wide_t'(p0b_q);
    assign w1 = wide_t'(p1a_q) - wide_t'(p1b_q);
    assign w2 = wide_t'(p2a_q) - wide_t'(p2b_q);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q     <= 1'b0;
            last_q      <= 1'b0;
            cov_valid_o <= 1'b0;
            cov_last_o  <= 1'b0;
        end else begin
            valid_q     <= pix_valid_i;
            last_q      <= pix_last_i;
            cov_valid_o <= valid_q && !w0[$high(w0)] && !w1[$high(w1)] && !w2[$high(w2)];
            cov_last_o  <= last_q;
        end
    end

    always_ff @(posedge clk) begin
        p0a_q   <= mul(pix_x_i, x1_i, y2_i, y1_i);
        p0b_q   <= mul(pix_y_i, y1_i, x2_i, x1_i);
        p1a_q   <= mul(pix_x_i, x2_i, y0_i, y2_i);
        p1b_q   <= mul(pix_y_i, y2_i, x0_i, x2_i);
        p2a_q   <= mul(pix_x_i, x0_i, y1_i, y0_i);
        p2b_q   <= mul(pix_y_i, y0_i, x1_i, x0_i);
        x_q     <= pix_x_i;
        y_q     <= pix_y_i;
        cov_x_o <= x_q;
        cov_y_o <= y_q;
    end

endmodule

/* hdl/vram_writer.sv */
// ==========================================================================
// VRAM write port. Runs the clear fill over the whole framebuffer and
// turns covered pixels into fill-colour writes, then reports job done.
// ==========================================================================

`timescale 1ns/1ps

module vram_writer #(
    parameter int FB_WIDTH  = 128,
    parameter int FB_HEIGHT = 128
) (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                clear_start_i,
    input  raster_pkg::color_t  clear_color_i,
    input  raster_pkg::color_t  fill_color_i,
    input  logic                cov_valid_i,
    input  logic                cov_last_i,
    input  raster_pkg::coord_t  cov_x_i,
    input  raster_pkg::coord_t  cov_y_i,
    output logic                vram_sel_o,
    output logic                vram_wr_o,
    output logic [31:0]         vram_addr_o,
    output raster_pkg::color_t  vram_data_o,
    output logic                job_done_o
);

    localparam logic [31:0] LAST_ADDR = 32'(FB_WIDTH * FB_HEIGHT - 1);

    logic        wr_q;
    logic        clearing_q;
    logic        draw_done_q;
    logic        clear_end;
    logic [31:0] pix_addr;

    assign clear_end = clearing_q && (vram_addr_o == LAST_ADDR);
    assign pix_addr  = 32'(cov_y_i) * 32'(FB_WIDTH) + 32'(cov_x_i);

    assign vram_sel_o  = wr_q;
    assign vram_wr_o   = wr_q;
    assign vram_data_o = clearing_q ? clear_color_i : fill_color_i;
    assign job_done_o  = clear_end || draw_done_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_q        <= 1'b0;
            clearing_q  <= 1'b0;
            draw_done_q <= 1'b0;
            vram_addr_o <= '0;
        end else begin
            draw_done_q <= cov_last_i;
            if (clear_start_i) begin
                wr_q        <= 1'b1;
                clearing_q  <= 1'b1;
                vram_addr_o <= '0;
            end else if (clearing_q) begin
                wr_q        <= !clear_end;
                clearing_q  <= !clear_end;
                vram_addr_o <= vram_addr_o + 32'd1;
            end else begin
                wr_q <= cov_valid_i;
                if (cov_valid_i) begin
                    vram_addr_o <= pix_addr;
                end
            end
        end
    end

endmodule

/* hdl/rasterizer_top.sv */
// ==========================================================================
// Rasterizer top level. Takes the command stream, drives the VRAM write
// port and the swap pulse, and chains the five pipeline stages.
// ==========================================================================

`timescale 1ns/1ps

module rasterizer_top #(
    parameter int FB_WIDTH  = 128,
    parameter int FB_HEIGHT = 128
) (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                cmd_valid_i,
    output logic                cmd_ready_o,
    input  raster_pkg::cmd_t    cmd_data_i,
    output logic                vram_sel_o,
    output logic                vram_wr_o,
    output logic [31:0]         vram_addr_o,
    output raster_pkg::color_t  vram_data_o,
    output logic                swap_o
);

    logic               draw_start, clear_start, scan_start, job_done;
    logic               pix_valid, pix_last, cov_valid, cov_last;
    raster_pkg::coord_t x0, y0, x1, y1, x2, y2;
    raster_pkg::coord_t min_x, min_y, max_x, max_y;
    raster_pkg::coord_t pix_x, pix_y, cov_x, cov_y;
    raster_pkg::color_t fill_color, clear_color;

    command_decoder u_decoder (
        .clk(clk), .reset_i(reset_i),
        .cmd_valid_i(cmd_valid_i), .cmd_data_i(cmd_data_i), .job_done_i(job_done),
        .cmd_ready_o(cmd_ready_o), .draw_start_o(draw_start),
        .clear_start_o(clear_start), .swap_o(swap_o),
        .x0_o(x0), .y0_o(y0), .x1_o(x1), .y1_o(y1), .x2_o(x2), .y2_o(y2),
        .fill_color_o(fill_color), .clear_color_o(clear_color)
    );

    bbox_setup #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) u_bbox (
        .clk(clk), .reset_i(reset_i), .draw_start_i(draw_start),
        .x0_i(x0), .y0_i(y0), .x1_i(x1), .y1_i(y1), .x2_i(x2), .y2_i(y2),
        .scan_start_o(scan_start),
        .min_x_o(min_x), .min_y_o(min_y), .max_x_o(max_x), .max_y_o(max_y)
    );

    pixel_scanner #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) u_scanner (
        .clk(clk), .reset_i(reset_i), .scan_start_i(scan_start),
        .min_x_i(min_x), .min_y_i(min_y), .max_x_i(max_x), .max_y_i(max_y),
        .pix_valid_o(pix_valid), .pix_last_o(pix_last), .pix_x_o(pix_x), .pix_y_o(pix_y)
    );

    edge_evaluator u_edges (
        .clk(clk), .reset_i(reset_i),
        .pix_valid_i(pix_valid), .pix_last_i(pix_last), .pix_x_i(pix_x), .pix_y_i(pix_y),
        .x0_i(x0), .y0_i(y0), .x1_i(x1), .y1_i(y1), .x2_i(x2), .y2_i(y2),
        .cov_valid_o(cov_valid), .cov_last_o(cov_last), .cov_x_o(cov_x), .cov_y_o(cov_y)
    );

    vram_writer #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) u_writer (
        .clk(clk), .reset_i(reset_i),
        .clear_start_i(clear_start), .clear_color_i(clear_color), .fill_color_i(fill_color),
        .cov_valid_i(cov_valid), .cov_last_i(cov_last), .cov_x_i(cov_x), .cov_y_i(cov_y),
        .vram_sel_o(vram_sel_o), .vram_wr_o(vram_wr_o), .vram_addr_o(vram_addr_o),
        .vram_data_o(vram_data_o), .job_done_o(job_done)
    );

endmodule

/* dv/rasterizer_tb.sv */
// ==========================================================================
// Testbench for the triangle rasterizer on a 16 x 12 framebuffer. Drives
// the command stream, mirrors VRAM writes into a shadow framebuffer and
// compares it with a reference image built from the edge-function rule.
// ==========================================================================

`timescale 1ns/1ps

module rasterizer_tb;

    localparam int FB_W    = 16;
    localparam int FB_H    = 12;
    localparam int FB_SIZE = FB_W * FB_H;
    // 22 draws of at most 192 pixels plus 4 clears stay under 6000 cycles
    localparam int MAX_CYCLES = 40000;

    logic               clk = 1'b0;
    logic               reset;
    logic               cmd_valid, cmd_ready;
    raster_pkg::cmd_t   cmd_data;
    logic               vram_sel, vram_wr, swap;
    logic [31:0]        vram_addr;
    raster_pkg::color_t vram_data;

    raster_pkg::color_t shadow_fb [FB_SIZE];
    raster_pkg::color_t expect_fb [FB_SIZE];
    int                 write_cnt [FB_SIZE];
    logic [31:0]        log_addr [$];
    raster_pkg::color_t log_data [$];
    int                 vx [3];
    int                 vy [3];
    logic [31:0]        rng_state = 32'h1328_74df;
    int                 cycles = 0;

    rasterizer_top #(.FB_WIDTH(FB_W), .FB_HEIGHT(FB_H)) DUT (
        .clk(clk), .reset_i(reset),
        .cmd_valid_i(cmd_valid), .cmd_ready_o(cmd_ready), .cmd_data_i(cmd_data),
        .vram_sel_o(vram_sel), .vram_wr_o(vram_wr), .vram_addr_o(vram_addr),
        .vram_data_o(vram_data), .swap_o(swap)
    );

    always #5 clk = ~clk;

    task automatic report_failure();
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_color(input string name, input raster_pkg::color_t exp,
                               input raster_pkg::color_t act);
        if (exp !== act) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("** Error %s: expected %b, actual %b", name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_addr(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (exp !== act) begin
            $display("** Error %s: expected %0d, actual %0d", name, exp, act);
            report_failure();
        end
    endtask

    // write monitor, samples the port on the edge that ends the write cycle
    always @(posedge clk) begin
        if (vram_sel && vram_wr) begin
            if (vram_addr >= FB_SIZE) begin
                $display("VRAM write to address %0d lies outside the framebuffer", vram_addr);
                report_failure();
            end else begin
                shadow_fb[vram_addr] = vram_data;
                write_cnt[vram_addr] = write_cnt[vram_addr] + 1;
                log_addr.push_back(vram_addr);
                log_data.push_back(vram_data);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            report_failure();
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] r;
        r = s ^ (s << 13);
        r = r ^ (r >> 17);
        return r ^ (r << 5);
    endfunction

    function automatic int next_in_range(input int lo, input int span);
        rng_state = xorshift(rng_state);
        return lo + int'(rng_state % span);
    endfunction

    // inside when no edge function is negative
    function automatic bit covered(input int x, input int y);
        int w0, w1, w2;
        w0 = (x - vx[1]) * (vy[2] - vy[1]) - (y - vy[1]) * (vx[2] - vx[1]);
        w1 = (x - vx[2]) * (vy[0] - vy[2]) - (y - vy[2]) * (vx[0] - vx[2]);
        w2 = (x - vx[0]) * (vy[1] - vy[0]) - (y - vy[0]) * (vx[1] - vx[0]);
        return (w0 >= 0) && (w1 >= 0) && (w2 >= 0);
    endfunction

    task automatic send(input logic [7:0] op, input logic [15:0] data);
        cmd_valid <= 1'b1;
        cmd_data  <= {op, 8'h00, data};
        do @(posedge clk); while (!cmd_ready);
        cmd_valid <= 1'b0;
    endtask

    task automatic wait_ready();
        do @(posedge clk); while (!cmd_ready);
    endtask

    task automatic clear_screen(input raster_pkg::color_t c);
        send(raster_pkg::OP_CLEAR, c);
        wait_ready();
        foreach (expect_fb[a]) expect_fb[a] = c;
    endtask

    task automatic load_triangle(input int x0, input int y0, input int x1, input int y1,
                                 input int x2, input int y2, input raster_pkg::color_t c);
        vx = '{x0, x1, x2};
        vy = '{y0, y1, y2};
        send(raster_pkg::OP_SET_X0, 16'(x0));
        send(raster_pkg::OP_SET_Y0, 16'(y0));
        send(raster_pkg::OP_SET_X1, 16'(x1));
        send(raster_pkg::OP_SET_Y1, 16'(y1));
        send(raster_pkg::OP_SET_X2, 16'(x2));
        send(raster_pkg::OP_SET_Y2, 16'(y2));
        send(raster_pkg::OP_SET_COLOR, c);
    endtask

    // expected image update and comparison, coverage limited to the vertex box
    task automatic check_draw(input string name, input raster_pkg::color_t c);
        int    lo_x, hi_x, lo_y, hi_y, a;
        bit    hit;
        string pix;
        lo_x = vx[0];
        hi_x = vx[0];
        lo_y = vy[0];
        hi_y = vy[0];
        for (int k = 1; k < 3; k++) begin
            lo_x = (vx[k] < lo_x) ? vx[k] : lo_x;
            hi_x = (vx[k] > hi_x) ? vx[k] : hi_x;
            lo_y = (vy[k] < lo_y) ? vy[k] : lo_y;
            hi_y = (vy[k] > hi_y) ? vy[k] : hi_y;
        end
        for (int y = 0; y < FB_H; y++) begin
            for (int x = 0; x < FB_W; x++) begin
                a   = y * FB_W + x;
                pix = $sformatf("%s pixel (%0d,%0d)", name, x, y);
                hit = covered(x, y) && x >= lo_x && x <= hi_x && y >= lo_y && y <= hi_y;
                if (hit) expect_fb[a] = c;
                check_flag({pix, " written"}, hit, write_cnt[a] != 0);
                check_flag({pix, " written twice"}, 1'b0, write_cnt[a] > 1);
                check_color(pix, expect_fb[a], shadow_fb[a]);
            end
        end
    endtask

    task automatic run_draw(input string name, input raster_pkg::color_t c);
        foreach (write_cnt[a]) write_cnt[a] = 0;
        send(raster_pkg::OP_DRAW, 16'h0000);
        wait_ready();
        check_draw(name, c);
    endtask

    initial begin
        raster_pkg::color_t col;
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd_data  = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_flag("reset ready", 1'b1, cmd_ready);
        check_flag("reset vram_sel", 1'b0, vram_sel);
        check_flag("reset vram_wr", 1'b0, vram_wr);
        check_flag("reset swap", 1'b0, swap);

        // full clear, in address order
        log_addr.delete();
        log_data.delete();
        clear_screen(16'hA5C3);
        check_addr("clear write count", FB_SIZE, log_addr.size());
        foreach (log_addr[i]) begin
            check_addr("clear address", i, log_addr[i]);
            check_color("clear data", 16'hA5C3, log_data[i]);
        end

        log_addr.delete();
        send(raster_pkg::OP_SWAP, 16'h0000);
        @(posedge clk);
        check_flag("swap pulse", 1'b1, swap);
        check_flag("ready gap after swap", 1'b0, cmd_ready);
        @(posedge clk);
        check_flag("swap pulse width", 1'b0, swap);
        check_flag("ready after swap", 1'b1, cmd_ready);
        repeat (4) @(posedge clk);
        check_addr("writes during swap", 0, log_addr.size());

        clear_screen(16'h0000);
        load_triangle(1, 1, 1, 10, 12, 1, 16'h07E0);
        run_draw("fixed triangle", 16'h07E0);

        // unknown opcode, then a redraw that relies on the held vertices
        log_addr.delete();
        send(8'h3C, 16'h0FFF);
        wait_ready();
        check_addr("writes after unknown opcode", 0, log_addr.size());
        send(raster_pkg::OP_SET_COLOR, 16'h1234);
        run_draw("repeat draw", 16'h1234);

        for (int t = 0; t < 20; t++) begin
            if (t % 10 == 0) clear_screen(16'(next_in_range(0, 65536)));
            col = 16'(next_in_range(0, 65536));
            load_triangle(next_in_range(-6, 28), next_in_range(-6, 24),
                          next_in_range(-6, 28), next_in_range(-6, 24),
                          next_in_range(-6, 28), next_in_range(-6, 24), col);
            run_draw($sformatf("random triangle %0d", t), col);
        end

        $display("All tests passed");
        $finish;
    end

endmodule

/* filelist.f */
hdl/raster_pkg.sv
hdl/command_decoder.sv
hdl/bbox_setup.sv
hdl/pixel_scanner.sv
hdl/edge_evaluator.sv
hdl/vram_writer.sv
hdl/rasterizer_top.sv
dv/rasterizer_tb.sv

/* Bender.yml */
package:
  name: rasterizer

sources:
  - hdl/raster_pkg.sv
  - hdl/command_decoder.sv
  - hdl/bbox_setup.sv
  - hdl/pixel_scanner.sv
  - hdl/edge_evaluator.sv
  - hdl/vram_writer.sv
  - hdl/rasterizer_top.sv
  - target: test
    files:
      - dv/rasterizer_tb.sv
